// File: include/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// ==============================
// core widths
// ==============================

// datapath and instruction width
`define DATA_W 32
// register index, 32 architectural registers
`define REG_ADDR_W 5
// data memory word address, 128 words
`define MEM_ADDR_W 7

// ==============================
// fixed values
// ==============================

// first fetch after reset
`define RESET_PC 32'h0000_0000
// jal writes its return address here
`define LINK_REG 5'd31

`endif

// File: src/mipsPkg.sv
package mipsPkg;

  // ==============================
  // instruction encodings
  // ==============================

  // primary opcode, inst[31:26]
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opLw    = 6'h23,
    opSw    = 6'h2B
  } opcodeE;

  // R-type function field, inst[5:0]
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2A
  } functE;

  // ==============================
  // ALU control
  // ==============================

  // operation class from the main decoder
  typedef enum logic [1:0] {
    aluOpAdd   = 2'b00,
    aluOpSub   = 2'b01,
    aluOpFunct = 2'b10
  } aluOpE;

  // ALU operation select, classic MIPS codes
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluOr  = 4'b0001,
    aluAdd = 4'b0010,
    aluSub = 4'b0110,
    aluSlt = 4'b0111,
    aluNop = 4'b1111
  } aluCtrlE;

endpackage

// File: src/pcUnit.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module pcUnit (
  input  logic               clk,
  input  logic               rst,
  input  logic               jump,
  input  logic               jumpReg,
  input  logic               branch,
  input  logic               aluZero,
  input  logic [25:0]        jumpTarget,
  input  logic [`DATA_W-1:0] branchOffset,
  input  logic [`DATA_W-1:0] regTarget,
  output logic [`DATA_W-1:0] pc,
  output logic [`DATA_W-1:0] pcPlus8
);

  logic [`DATA_W-1:0] pcPlus4;
  logic [`DATA_W-1:0] nextPc;

  // sequential successors
  assign pcPlus4 = pc + `DATA_W'd4;
  // jal return address, no delay slot
  assign pcPlus8 = pc + `DATA_W'd8;

  // ==============================
  // next pc select
  // ==============================

  always_comb begin
    // jr has top priority
    if (jumpReg) begin
      nextPc = regTarget;
    end else if (jump) begin
      // pseudo-direct, keep the region bits of pc+4
      nextPc = {pcPlus4[`DATA_W-1:28], jumpTarget, 2'b00};
    end else if (branch && aluZero) begin
      // offset arrives already word-shifted
      nextPc = pcPlus4 + branchOffset;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // pc register
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

// File: src/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
  import mipsPkg::*;
(
  input  opcodeE opcode,
  input  functE  funct,
  output logic   regDst,
  output logic   aluSrc,
  output logic   memToReg,
  output logic   regWrite,
  output logic   memRead,
  output logic   memWrite,
  output logic   jump,
  output logic   jumpReg,
  output logic   link,
  output logic   branch,
  output aluOpE  aluOp
);

  // ==============================
  // main decoder
  // ==============================

  always_comb begin
    // defaults give a no-op
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    jump     = 1'b0;
    jumpReg  = 1'b0;
    link     = 1'b0;
    branch   = 1'b0;
    aluOp    = aluOpAdd;
    case (opcode)
      opRtype: begin
        // funct picks between alu ops, jr and no-op
        case (funct)
          fnAdd, fnSub, fnAnd, fnOr, fnSlt: begin
            regDst   = 1'b1;
            regWrite = 1'b1;
            aluOp    = aluOpFunct;
          end
          fnJr: jumpReg = 1'b1;
          // unknown funct stays a no-op
          default: ;
        endcase
      end
      opLw: begin
        // base plus offset, data from memory
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      opBeq: begin
        // compare by subtraction, zero flag decides
        branch = 1'b1;
        aluOp  = aluOpSub;
      end
      opJ: jump = 1'b1;
      opJal: begin
        // write pc+8 to the link register
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: src/aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder
  import mipsPkg::*;
(
  input  aluOpE   aluOp,
  input  functE   funct,
  output aluCtrlE aluCtrl
);

  // ==============================
  // alu control decode
  // ==============================

  always_comb begin
    case (aluOp)
      // lw and sw address calc
      aluOpAdd: aluCtrl = aluAdd;
      // beq compare
      aluOpSub: aluCtrl = aluSub;
      aluOpFunct: begin
        // R-type, operation from funct
        case (funct)
          fnAdd:   aluCtrl = aluAdd;
          fnSub:   aluCtrl = aluSub;
          fnAnd:   aluCtrl = aluAnd;
          fnOr:    aluCtrl = aluOr;
          fnSlt:   aluCtrl = aluSlt;
          // jr and unknown functs
          default: aluCtrl = aluNop;
        endcase
      end
      default: aluCtrl = aluNop;
    endcase
  end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module alu
  import mipsPkg::*;
(
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  aluCtrlE            aluCtrl,
  output logic [`DATA_W-1:0] result,
  output logic               zero
);

  logic lessThan;

  // signed compare for slt
  assign lessThan = $signed(a) < $signed(b);

  // ==============================
  // operation select
  // ==============================

  always_comb begin
    case (aluCtrl)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // 1 or 0, zero-extended
      aluSlt: result = {{(`DATA_W-1){1'b0}}, lessThan};
      // nop and unused codes
      default: result = '0;
    endcase
  end

  // flag on the result alone
  // beq only looks at it after a subtract
  assign zero = (result == '0);

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module regFile (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  writeEn,
  input  logic [`REG_ADDR_W-1:0] readAddr1,
  input  logic [`REG_ADDR_W-1:0] readAddr2,
  input  logic [`REG_ADDR_W-1:0] writeAddr,
  input  logic [`DATA_W-1:0]     writeData,
  output logic [`DATA_W-1:0]     readData1,
  output logic [`DATA_W-1:0]     readData2
);

  localparam int NumRegs = 1 << `REG_ADDR_W;

  // r1 to r31, r0 has no storage
  logic [`DATA_W-1:0] regs [1:NumRegs-1];

  // ==============================
  // write port
  // ==============================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // writes to r0 dropped here
      regs[writeAddr] <= writeData;
    end
  end

  // ==============================
  // read ports
  // ==============================

  // combinational, r0 reads as zero
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

// File: src/mipsTop.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mipsTop
  import mipsPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`DATA_W-1:0]     inst,
  input  logic [`DATA_W-1:0]     memRdata,
  output logic [`DATA_W-1:0]     instAddr,
  output logic                   memCen,
  output logic                   memWen,
  output logic                   memOen,
  output logic [`MEM_ADDR_W-1:0] memAddr,
  output logic [`DATA_W-1:0]     memWdata,
  output logic                   rfWriteEn,
  output logic [`REG_ADDR_W-1:0] rfWriteAddr,
  output logic [`DATA_W-1:0]     rfWriteData
);

  opcodeE                 opcode;
  functE                  funct;
  logic [`REG_ADDR_W-1:0] rs, rt, rd;
  logic [15:0]            imm16;
  logic [`DATA_W-1:0]     signExt, branchOffset;
  logic                   regDst, aluSrc, memToReg, regWrite, memRead, memWrite;
  logic                   jump, jumpReg, link, branch;
  aluOpE                  aluOp;
  aluCtrlE                aluCtrl;
  logic [`DATA_W-1:0]     pc, pcPlus8, readData1, readData2, aluB, aluResult;
  logic                   aluZero;

  // ==============================
  // instruction fields
  // ==============================

  assign opcode = opcodeE'(inst[31:26]);
  assign funct  = functE'(inst[5:0]);
  assign rs     = inst[25:21];
  assign rt     = inst[20:16];
  assign rd     = inst[15:11];
  assign imm16  = inst[15:0];

  // sign extend, then word offset for beq
  assign signExt      = {{(`DATA_W-16){imm16[15]}}, imm16};
  assign branchOffset = {signExt[`DATA_W-3:0], 2'b00};

  pcUnit i_pcUnit (
    .clk(clk), .rst(rst), .jump(jump), .jumpReg(jumpReg), .branch(branch),
    .aluZero(aluZero), .jumpTarget(inst[25:0]), .branchOffset(branchOffset),
    .regTarget(readData1), .pc(pc), .pcPlus8(pcPlus8)
  );

  controlUnit i_controlUnit (
    .opcode(opcode), .funct(funct), .regDst(regDst), .aluSrc(aluSrc),
    .memToReg(memToReg), .regWrite(regWrite), .memRead(memRead),
    .memWrite(memWrite), .jump(jump), .jumpReg(jumpReg), .link(link),
    .branch(branch), .aluOp(aluOp)
  );

  aluDecoder i_aluDecoder (.aluOp(aluOp), .funct(funct), .aluCtrl(aluCtrl));

  // offset for lw/sw, rt otherwise
  assign aluB = aluSrc ? signExt : readData2;

  alu i_alu (
    .a(readData1), .b(aluB), .aluCtrl(aluCtrl), .result(aluResult), .zero(aluZero)
  );

  regFile i_regFile (
    .clk(clk), .rst(rst), .writeEn(rfWriteEn), .readAddr1(rs), .readAddr2(rt),
    .writeAddr(rfWriteAddr), .writeData(rfWriteData),
    .readData1(readData1), .readData2(readData2)
  );

  // ==============================
  // write back and memory port
  // ==============================

  // destination: r31 for jal, rd for R-type, rt for lw
  assign rfWriteAddr = link ? `LINK_REG : (regDst ? rd : rt);
  // data: return address, load data or alu
  assign rfWriteData = link ? pcPlus8 : (memToReg ? memRdata : aluResult);
  // no commit while in reset
  assign rfWriteEn   = rst && regWrite;

  assign instAddr = pc;

  // active-low strobes, held off in reset
  assign memCen   = !(rst && (memRead || memWrite));
  assign memWen   = !(rst && memWrite);
  assign memOen   = !(rst && memRead);
  // byte address to word address
  assign memAddr  = aluResult[`MEM_ADDR_W+1:2];
  assign memWdata = readData2;

endmodule

// File: verif/mips_chk.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mipsChk (
  input logic               clk,
  input logic               rst,
  input logic [`DATA_W-1:0] instAddr,
  input logic               memCen,
  input logic               memWen,
  input logic               memOen,
  input logic               rfWriteEn
);

  // ==============================
  // memory strobes
  // ==============================

  // everything quiet while reset is low
  resetQuiet: assert property (@(posedge clk)
    !rst |-> (memCen && memWen && memOen && !rfWriteEn))
    else $error("memory strobe or register write active during reset");

  // a write always selects the chip
  writeSelects: assert property (@(posedge clk) disable iff (!rst)
    !memWen |-> !memCen)
    else $error("memWen low without memCen low");

  // read and write strobes exclusive
  noReadWrite: assert property (@(posedge clk) !(!memOen && !memWen))
    else $error("memOen and memWen low together");

  // ==============================
  // reset values
  // ==============================

  // first cycle out of reset fetches from the reset pc
  firstFetch: assert property (@(posedge clk) $rose(rst) |-> (instAddr == `RESET_PC))
    else $error("first fetch after reset not from the reset pc");

endmodule

bind mipsTop mipsChk i_mipsChk (
  .clk(clk), .rst(rst), .instAddr(instAddr), .memCen(memCen), .memWen(memWen),
  .memOen(memOen), .rfWriteEn(rfWriteEn)
);

// File: verif/tbMips.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module tbMips
  import mipsPkg::*;
();

  localparam int Period      = 100;
  localparam int ResetCycles = 10;
  // 10 reset cycles plus about 25 executed instructions, wide margin
  localparam int CycleLimit  = 200;
  localparam int RomWords    = 32;
  localparam int MemWords    = 1 << `MEM_ADDR_W;
  localparam logic [31:0] Seed = 32'd82;

  logic                   clk;
  logic                   rst;
  logic [`DATA_W-1:0]     inst;
  logic [`DATA_W-1:0]     memRdata;
  logic [`DATA_W-1:0]     instAddr;
  logic                   memCen;
  logic                   memWen;
  logic                   memOen;
  logic [`MEM_ADDR_W-1:0] memAddr;
  logic [`DATA_W-1:0]     memWdata;
  logic                   rfWriteEn;
  logic [`REG_ADDR_W-1:0] rfWriteAddr;
  logic [`DATA_W-1:0]     rfWriteData;

  // program rom and data memory behind the DUT ports
  logic [`DATA_W-1:0] rom [0:RomWords-1];
  logic [`DATA_W-1:0] dmem [0:MemWords-1];

  // reference model state
  logic [`DATA_W-1:0] refPc;
  logic [`DATA_W-1:0] refRegs [0:31];
  logic [`DATA_W-1:0] refMem [0:MemWords-1];

  int errors;
  int checks;
  int cycles;
  int loops;

  mipsTop i_mipsTop (
    .clk(clk),
    .rst(rst),
    .inst(inst),
    .memRdata(memRdata),
    .instAddr(instAddr),
    .memCen(memCen),
    .memWen(memWen),
    .memOen(memOen),
    .memAddr(memAddr),
    .memWdata(memWdata),
    .rfWriteEn(rfWriteEn),
    .rfWriteAddr(rfWriteAddr),
    .rfWriteData(rfWriteData)
  );

  // ==============================
  // memories and clock
  // ==============================

  // zero-wait fetch, word index from pc
  assign inst     = rom[instAddr[6:2]];
  // read data only while selected for read
  assign memRdata = (!memCen && !memOen) ? dmem[memAddr] : '0;

  // sw lands at the edge that ends its cycle
  always @(posedge clk) begin
    if (!memCen && !memWen) begin
      dmem[memAddr] = memWdata;
    end
  end

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("timeout: program did not reach its final loop within %0d cycles", CycleLimit);
      $display("Verification failed");
      $finish;
    end
  end

  // ==============================
  // helpers
  // ==============================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  // same random image for the DUT memory and the model
  task automatic presetMemory();
    logic [31:0] state;
    state = Seed;
    for (int i = 0; i < MemWords; i++) begin
      state   = xorshift32(state);
      dmem[i] = state;
    end
    // r1 source positive, r2 source negative, so slt sees a sign mix
    dmem[0][31] = 1'b0;
    dmem[1][31] = 1'b1;
    for (int i = 0; i < MemWords; i++) begin
      refMem[i] = dmem[i];
    end
  endtask

  task automatic loadProgram();
    // empty slots hold sll r0, an unsupported funct
    for (int i = 0; i < RomWords; i++) begin
      rom[i] = '0;
    end
    rom[0]  = encodeI(opLw, 5'd0, 5'd1, 16'd0);
    rom[1]  = encodeI(opLw, 5'd0, 5'd2, 16'd4);
    rom[2]  = encodeI(opLw, 5'd0, 5'd3, 16'd8);
    rom[3]  = encodeR(5'd1, 5'd3, 5'd4, fnAdd);
    rom[4]  = encodeR(5'd1, 5'd2, 5'd5, fnSub);
    rom[5]  = encodeR(5'd1, 5'd3, 5'd6, fnAnd);
    rom[6]  = encodeR(5'd2, 5'd3, 5'd7, fnOr);
    rom[7]  = encodeR(5'd2, 5'd1, 5'd8, fnSlt);
    rom[8]  = encodeR(5'd1, 5'd2, 5'd9, fnSlt);
    // write to r0, dropped
    rom[9]  = encodeR(5'd1, 5'd3, 5'd0, fnAdd);
    rom[10] = encodeI(opSw, 5'd0, 5'd4, 16'd64);
    rom[11] = encodeI(opLw, 5'd0, 5'd10, 16'd64);
    // r0 read back through rs
    rom[12] = encodeR(5'd0, 5'd1, 5'd11, fnAdd);
    // taken, skips 14 and 15
    rom[13] = encodeI(opBeq, 5'd1, 5'd1, 16'd2);
    rom[14] = encodeR(5'd1, 5'd1, 5'd12, fnAdd);
    rom[15] = encodeR(5'd2, 5'd2, 5'd12, fnAdd);
    // not taken
    rom[16] = encodeI(opBeq, 5'd1, 5'd2, 16'd5);
    rom[17] = encodeJ(opJal, 26'd20);
    // pc+8 link skips this slot
    rom[18] = encodeR(5'd1, 5'd1, 5'd12, fnAdd);
    rom[19] = encodeJ(opJ, 26'd23);
    // addi opcode, unsupported here
    rom[20] = encodeI(6'h08, 5'd1, 5'd14, 16'h1234);
    rom[21] = encodeR(5'd1, 5'd2, 5'd15, 6'h00);
    rom[22] = encodeR(5'd31, 5'd0, 5'd0, fnJr);
    rom[23] = encodeI(opSw, 5'd0, 5'd5, 16'd68);
    rom[24] = encodeI(opLw, 5'd0, 5'd13, 16'd68);
    rom[25] = encodeJ(opJ, 26'd25);
  endtask

  task automatic checkValue(input string test, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("CHECK FAILED %s %s at pc %h: expected %h, actual %h",
               test, field, refPc, expected, actual);
    end
  endtask

  task automatic checkReset();
    checkValue("reset", "instAddr", `RESET_PC, instAddr);
    checkValue("reset", "rfWriteEn", 32'd0, 32'(rfWriteEn));
    checkValue("reset", "memCen", 32'd1, 32'(memCen));
    checkValue("reset", "memWen", 32'd1, 32'(memWen));
    checkValue("reset", "memOen", 32'd1, 32'(memOen));
  endtask

  // ==============================
  // ISA reference model
  // ==============================

  // predict one instruction, compare, then commit model state
  task automatic stepModel();
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sext;
    logic [31:0] addr;
    logic [31:0] nextPc;
    logic [31:0] expWd;
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  expWa;
    logic        expWe;
    logic        expCen;
    logic        expWen;
    logic        expOen;
    string       name;
    word   = rom[refPc[6:2]];
    op     = word[31:26];
    fn     = word[5:0];
    a      = refRegs[word[25:21]];
    b      = refRegs[word[20:16]];
    sext   = {{16{word[15]}}, word[15:0]};
    addr   = a + sext;
    nextPc = refPc + 32'd4;
    expWe  = 1'b0;
    expWa  = word[20:16];
    expWd  = '0;
    expCen = 1'b1;
    expWen = 1'b1;
    expOen = 1'b1;
    name   = "nop-opcode";
    case (op)
      opRtype: begin
        name  = "rtype";
        expWe = 1'b1;
        expWa = word[15:11];
        case (fn)
          fnAdd: expWd = a + b;
          fnSub: expWd = a - b;
          fnAnd: expWd = a & b;
          fnOr:  expWd = a | b;
          fnSlt: expWd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fnJr: begin
            name   = "jr";
            expWe  = 1'b0;
            nextPc = a;
          end
          default: begin
            name  = "nop-funct";
            expWe = 1'b0;
          end
        endcase
      end
      opLw: begin
        name   = "lw";
        expWe  = 1'b1;
        expWd  = refMem[addr[`MEM_ADDR_W+1:2]];
        expCen = 1'b0;
        expOen = 1'b0;
      end
      opSw: begin
        name   = "sw";
        expCen = 1'b0;
        expWen = 1'b0;
      end
      opBeq: begin
        name = "beq";
        if (a == b) begin
          nextPc = refPc + 32'd4 + (sext << 2);
        end
      end
      opJ: begin
        name   = "j";
        nextPc = {nextPc[31:28], word[25:0], 2'b00};
      end
      opJal: begin
        name   = "jal";
        expWe  = 1'b1;
        expWa  = `LINK_REG;
        expWd  = refPc + 32'd8;
        nextPc = {nextPc[31:28], word[25:0], 2'b00};
      end
      default: ;
    endcase

    checkValue(name, "instAddr", refPc, instAddr);
    checkValue(name, "rfWriteEn", 32'(expWe), 32'(rfWriteEn));
    // address and data only matter with a write
    if (expWe) begin
      checkValue(name, "rfWriteAddr", 32'(expWa), 32'(rfWriteAddr));
      checkValue(name, "rfWriteData", expWd, rfWriteData);
    end
    checkValue(name, "memCen", 32'(expCen), 32'(memCen));
    checkValue(name, "memWen", 32'(expWen), 32'(memWen));
    checkValue(name, "memOen", 32'(expOen), 32'(memOen));
    if (!expCen) begin
      checkValue(name, "memAddr", 32'(addr[`MEM_ADDR_W+1:2]), 32'(memAddr));
    end
    if (!expWen) begin
      checkValue(name, "memWdata", b, memWdata);
    end

    // commit, r0 stays zero
    if (expWe && (expWa != '0)) begin
      refRegs[expWa] = expWd;
    end
    if (!expWen) begin
      refMem[addr[`MEM_ADDR_W+1:2]] = b;
    end
    if (nextPc == refPc) begin
      loops++;
    end
    refPc = nextPc;
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    rst    = 1'b0;
    errors = 0;
    checks = 0;
    cycles = 0;
    loops  = 0;
    presetMemory();
    loadProgram();
    refPc = `RESET_PC;
    for (int r = 0; r < 32; r++) begin
      refRegs[r] = '0;
    end
    // compare a quarter period after each falling edge
    repeat (ResetCycles) begin
      #(Period / 4);
      checkReset();
      @(negedge clk);
    end
    rst = 1'b1;
    // run until the final self-jump has been seen twice
    while (loops < 2) begin
      #(Period / 4);
      stepModel();
      @(negedge clk);
    end
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+include
src/mipsPkg.sv
src/pcUnit.sv
src/controlUnit.sv
src/aluDecoder.sv
src/alu.sv
src/regFile.sv
src/mipsTop.sv
verif/mips_chk.sv
verif/tbMips.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the MIPS testbench with Verilator, verdict from the simulation log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -j 0 --top-module tbMips -f all.f -o tbMips \
  > build.log 2>&1 \
  && ./obj_dir/tbMips > "$LOG" 2>&1 \
  || { cat build.log >> "$LOG"; echo "build or simulation did not complete" >> "$LOG"; }

cat "$LOG"
grep -q "Verification failed" "$LOG" && exit 1
grep -q "Verification passed" "$LOG" || exit 1
exit 0
